//--- design/busPkg.sv
package busPkg;

	localparam int dataWidth = 32;
	localparam int regIdxWidth = 4;
	localparam int addrWidth = 8;	// AXI byte address, 0x00 to 0xFF

	typedef enum logic [4:0] {
		opAdd = 5'd3,
		opSub = 5'd4,
		opAnd = 5'd5,
		opOr = 5'd6,
		opRor = 5'd8,
		opShr = 5'd9,
		opShl = 5'd11
	} opCode;

	typedef struct packed {
		logic [4:0] op;	// raw field, any other code is a no-op
		logic [regIdxWidth-1:0] ra;	// destination
		logic [regIdxWidth-1:0] rb;	// first operand, goes to Y
		logic [regIdxWidth-1:0] rc;	// second operand, on the bus at T4
		logic [14:0] spare;
	} instrFields;

	typedef enum logic [2:0] {
		srcNone,
		srcPc,
		srcMdr,
		srcReg,
		srcZLow
	} busSrc;

	typedef struct packed {
		busSrc src;
		logic [regIdxWidth-1:0] regSel;	// read and write index
		logic regIn;
		logic pcIn;
		logic marIn;
		logic mdrIn;
		logic irIn;
		logic yIn;
		logic zIn;
		logic incPc;
		logic read;	// MDR takes the memory word instead of the bus
		opCode aluOp;
	} ctrlBus;

	localparam logic [addrWidth-1:0] offStatus = 8'h00;
	localparam logic [addrWidth-1:0] offMemData = 8'h04;
	localparam logic [addrWidth-1:0] offLoad = 8'h08;
	localparam logic [addrWidth-1:0] offExec = 8'h0C;
	localparam logic [addrWidth-1:0] offPc = 8'h10;
	localparam logic [addrWidth-1:0] offRegBase = 8'h40;

endpackage

//--- design/regFile.sv
`timescale 1ns/1ps
module regFile import busPkg::*; #(
	parameter int numRegs = 16,
	parameter int dataWidth = busPkg::dataWidth
) (
	input logic Clock,
	input logic rstN,
	input ctrlBus ctrl,
	input logic [dataWidth-1:0] busValue,
	output logic [dataWidth-1:0] regOut,
	input logic [regIdxWidth-1:0] hostIdx,
	output logic [dataWidth-1:0] hostData
);

	logic [dataWidth-1:0] regs [numRegs];

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (ctrl.regIn) begin
			regs[ctrl.regSel] <= busValue;	// R0 is an ordinary register
		end
	end

	// bus-side read, follows regSel in the same cycle
	always_comb begin
		regOut = '0;
		if (ctrl.regSel < numRegs) begin
			regOut = regs[ctrl.regSel];
		end
	end

	always_comb begin
		hostData = '0;	// out-of-range index reads zero
		if (hostIdx < numRegs) begin
			hostData = regs[hostIdx];
		end
	end

endmodule

//--- design/busRegs.sv
`timescale 1ns/1ps
module busRegs import busPkg::*; #(
	parameter int dataWidth = busPkg::dataWidth
) (
	input logic Clock,
	input logic rstN,
	input ctrlBus ctrl,
	input logic [dataWidth-1:0] memData,
	input logic [dataWidth-1:0] regOut,
	input logic [dataWidth-1:0] zLow,
	output logic [dataWidth-1:0] busValue,
	output instrFields irWord,
	output logic [dataWidth-1:0] pcValue
);

	logic [dataWidth-1:0] pc;
	logic [dataWidth-1:0] mar;	// address register, no memory behind it
	logic [dataWidth-1:0] mdr;
	logic [dataWidth-1:0] ir;

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			pc <= '0;
			mar <= '0;
			mdr <= '0;
			ir <= '0;
		end else begin
			if (ctrl.pcIn) begin
				pc <= busValue;
			end else if (ctrl.incPc) begin
				pc <= pc + 1'b1;	// word-counting PC
			end
			if (ctrl.marIn) begin
				mar <= busValue;
			end
			if (ctrl.mdrIn) begin
				mdr <= ctrl.read ? memData : busValue;
			end
			if (ctrl.irIn) begin
				ir <= busValue;
			end
		end
	end

	// only one source drives the bus at a time
	always_comb begin
		case (ctrl.src)
			srcPc: busValue = pc;
			srcMdr: busValue = mdr;
			srcReg: busValue = regOut;
			srcZLow: busValue = zLow;
			default: busValue = '0;
		endcase
	end

	assign irWord = ir;
	assign pcValue = pc;

endmodule

//--- design/aluUnit.sv
`timescale 1ns/1ps
module aluUnit import busPkg::*; #(
	parameter int dataWidth = busPkg::dataWidth
) (
	input logic Clock,
	input logic rstN,
	input ctrlBus ctrl,
	input logic [dataWidth-1:0] busValue,
	output logic [dataWidth-1:0] zLow
);

	localparam int shiftWidth = $clog2(dataWidth);

	logic [dataWidth-1:0] yReg;
	logic [dataWidth-1:0] aluResult;
	logic [shiftWidth-1:0] shamt;

	assign shamt = busValue[shiftWidth-1:0];	// low bits of second operand only

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			yReg <= '0;
		end else if (ctrl.yIn) begin
			yReg <= busValue;
		end
	end

	// Y is the first operand, the bus carries the second
	always_comb begin
		case (ctrl.aluOp)
			opAdd: aluResult = yReg + busValue;	// wraps
			opSub: aluResult = yReg - busValue;
			opAnd: aluResult = yReg & busValue;
			opOr: aluResult = yReg | busValue;
			opShr: aluResult = yReg >> shamt;
			opShl: aluResult = yReg << shamt;
			opRor: begin
				// shift by full width gives zero, so shamt of 0 is a plain copy
				aluResult = (yReg >> shamt) | (yReg << (dataWidth - int'(shamt)));
			end
			default: aluResult = '0;
		endcase
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			zLow <= '0;
		end else if (ctrl.zIn) begin
			zLow <= aluResult;
		end
	end

endmodule

//--- design/cpuControl.sv
`timescale 1ns/1ps
module cpuControl import busPkg::*; (
	input logic Clock,
	input logic rstN,
	input logic cmdValid,
	input logic cmdLoad,
	input logic cmdExec,
	input logic [regIdxWidth-1:0] cmdReg,
	input instrFields irWord,
	output logic busy,
	output ctrlBus ctrl
);

	typedef enum logic [8:0] {
		sIdle = 9'b000000001,
		sL0 = 9'b000000010,
		sL1 = 9'b000000100,
		sT0 = 9'b000001000,
		sT1 = 9'b000010000,
		sT2 = 9'b000100000,
		sT3 = 9'b001000000,
		sT4 = 9'b010000000,
		sT5 = 9'b100000000
	} phase;

	phase state;
	logic [regIdxWidth-1:0] loadReg;	// target of the pending load
	logic opLegal;

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			state <= sIdle;
			loadReg <= '0;
		end else begin
			case (state)
				sIdle: begin
					if (cmdValid && cmdLoad) begin
						state <= sL0;
						loadReg <= cmdReg;
					end else if (cmdValid && cmdExec) begin
						state <= sT0;
					end
				end
				sL0: state <= sL1;
				sL1: state <= sIdle;
				sT0: state <= sT1;
				sT1: state <= sT2;
				sT2: state <= sT3;
				sT3: state <= sT4;
				sT4: state <= sT5;
				default: state <= sIdle;	// T5 and any illegal code
			endcase
		end
	end

	assign busy = (state != sIdle);

	// IR is stable from T3 on, so the opcode decode is valid there
	always_comb begin
		case (irWord.op)
			opAdd, opSub, opAnd, opOr, opRor, opShr, opShl: opLegal = 1'b1;
			default: opLegal = 1'b0;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.src = srcNone;
		case (state)
			sL0: begin
				ctrl.read = 1'b1;
				ctrl.mdrIn = 1'b1;
			end
			sL1: begin
				ctrl.src = srcMdr;
				ctrl.regSel = loadReg;
				ctrl.regIn = 1'b1;
			end
			sT0: begin
				ctrl.src = srcPc;
				ctrl.marIn = 1'b1;
				ctrl.incPc = 1'b1;
			end
			sT1: begin
				ctrl.read = 1'b1;
				ctrl.mdrIn = 1'b1;
			end
			sT2: begin
				ctrl.src = srcMdr;
				ctrl.irIn = 1'b1;
			end
			sT3: begin
				ctrl.src = srcReg;
				ctrl.regSel = irWord.rb;
				ctrl.yIn = opLegal;
			end
			sT4: begin
				ctrl.src = srcReg;
				ctrl.regSel = irWord.rc;
				ctrl.aluOp = opCode'(irWord.op);
				ctrl.zIn = opLegal;
			end
			sT5: begin
				ctrl.src = srcZLow;
				ctrl.regSel = irWord.ra;
				ctrl.regIn = opLegal;	// no-op leaves Ra alone
			end
			default: ;
		endcase
	end

endmodule

//--- design/axiLiteSlave.sv
`timescale 1ns/1ps
module axiLiteSlave import busPkg::*; #(
	parameter int dataWidth = busPkg::dataWidth
) (
	input logic Clock,
	input logic rstN,
	input logic [addrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [dataWidth-1:0] wdata,
	input logic [dataWidth/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [addrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [dataWidth-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic busy,
	input logic [dataWidth-1:0] hostData,
	input logic [dataWidth-1:0] pcValue,
	output logic [regIdxWidth-1:0] hostIdx,
	output logic [dataWidth-1:0] memData,
	output logic cmdValid,
	output logic cmdLoad,
	output logic cmdExec,
	output logic [regIdxWidth-1:0] cmdReg
);

	logic isLoad;
	logic isExec;
	logic isCmd;
	logic wrFire;
	logic arFire;
	logic inRegSpace;
	logic [dataWidth-1:0] readWord;

	assign isLoad = (awaddr == offLoad);
	assign isExec = (awaddr == offExec);
	assign isCmd = isLoad | isExec;

	// AW and W are taken together, one write outstanding at a time
	assign wrFire = awvalid & wvalid & ~bvalid & ~(isCmd & busy);
	assign awready = wrFire;
	assign wready = wrFire;

	assign cmdValid = wrFire & isCmd;	// single-cycle pulse on the handshake
	assign cmdLoad = isLoad;
	assign cmdExec = isExec;
	assign cmdReg = wdata[regIdxWidth-1:0];

	assign arready = ~rvalid;
	assign arFire = arvalid & arready;
	assign hostIdx = araddr[2 +: regIdxWidth];
	assign inRegSpace = (araddr[addrWidth-1:regIdxWidth+2] ==
		offRegBase[addrWidth-1:regIdxWidth+2]);

	assign bresp = 2'b00;	// always OKAY
	assign rresp = 2'b00;

	always_comb begin
		readWord = '0;	// unknown offsets read zero
		if (araddr == offStatus) begin
			readWord = {{(dataWidth-1){1'b0}}, busy};
		end else if (araddr == offPc) begin
			readWord = pcValue;
		end else if (inRegSpace) begin
			readWord = hostData;
		end
	end

	// memory word, byte strobes honoured
	always_ff @(posedge Clock) begin
		if (!rstN) begin
			memData <= '0;
		end else if (wrFire && awaddr == offMemData) begin
			for (int b = 0; b < dataWidth/8; b++) begin
				if (wstrb[b]) begin
					memData[8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			bvalid <= 1'b0;
		end else if (wrFire) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rstN) begin
			rvalid <= 1'b0;
			rdata <= '0;
		end else if (arFire) begin
			rvalid <= 1'b1;
			rdata <= readWord;	// sampled at the AR handshake
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

endmodule

//--- design/cpuTop.sv
`timescale 1ns/1ps
module cpuTop import busPkg::*; #(
	parameter int numRegs = 16,
	parameter int dataWidth = busPkg::dataWidth
) (
	input logic Clock,
	input logic rstN,
	input logic [addrWidth-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [dataWidth-1:0] wdata,
	input logic [dataWidth/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [addrWidth-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [dataWidth-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready
);

	ctrlBus ctrl;
	instrFields irWord;
	logic busy;
	logic cmdValid;
	logic cmdLoad;
	logic cmdExec;
	logic [regIdxWidth-1:0] cmdReg;
	logic [regIdxWidth-1:0] hostIdx;
	logic [dataWidth-1:0] hostData;
	logic [dataWidth-1:0] memData;
	logic [dataWidth-1:0] pcValue;
	logic [dataWidth-1:0] busValue;
	logic [dataWidth-1:0] regOut;
	logic [dataWidth-1:0] zLow;

	axiLiteSlave #(.dataWidth(dataWidth)) axiLiteSlave_inst (
		.Clock(Clock), .rstN(rstN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.busy(busy), .hostData(hostData), .pcValue(pcValue), .hostIdx(hostIdx),
		.memData(memData), .cmdValid(cmdValid), .cmdLoad(cmdLoad),
		.cmdExec(cmdExec), .cmdReg(cmdReg)
	);

	cpuControl cpuControl_inst (
		.Clock(Clock), .rstN(rstN),
		.cmdValid(cmdValid), .cmdLoad(cmdLoad), .cmdExec(cmdExec), .cmdReg(cmdReg),
		.irWord(irWord), .busy(busy), .ctrl(ctrl)
	);

	regFile #(.numRegs(numRegs), .dataWidth(dataWidth)) regFile_inst (
		.Clock(Clock), .rstN(rstN), .ctrl(ctrl), .busValue(busValue),
		.regOut(regOut), .hostIdx(hostIdx), .hostData(hostData)
	);

	busRegs #(.dataWidth(dataWidth)) busRegs_inst (
		.Clock(Clock), .rstN(rstN), .ctrl(ctrl), .memData(memData),
		.regOut(regOut), .zLow(zLow), .busValue(busValue),
		.irWord(irWord), .pcValue(pcValue)
	);

	aluUnit #(.dataWidth(dataWidth)) aluUnit_inst (
		.Clock(Clock), .rstN(rstN), .ctrl(ctrl), .busValue(busValue), .zLow(zLow)
	);

endmodule

//--- testbench/cpuTop_properties.sv
`timescale 1ns/1ps
module cpuTop_properties import busPkg::*; (
	input logic Clock,
	input logic rstN,
	input logic busy,
	input ctrlBus ctrl,
	input logic bvalid,
	input logic bready
);

	int failures = 0;	// read back by the testbench at the end
	logic anyEnable;

	assign anyEnable = ctrl.regIn | ctrl.pcIn | ctrl.marIn | ctrl.mdrIn | ctrl.irIn |
		ctrl.yIn | ctrl.zIn | ctrl.incPc | ctrl.read;

	idleQuiet: assert property (@(posedge Clock) disable iff (!rstN)
		!busy |-> !anyEnable && ctrl.src == srcNone)
		else begin
			$error("control enables active while the sequencer is idle");
			failures++;
		end

	// a memory read feeds at most one register
	readTarget: assert property (@(posedge Clock) disable iff (!rstN)
		ctrl.read |-> !(ctrl.mdrIn && ctrl.irIn))
		else begin
			$error("read strobe raised with both mdrIn and irIn");
			failures++;
		end

	bvalidHold: assert property (@(posedge Clock) disable iff (!rstN)
		bvalid && !bready |=> bvalid)
		else begin
			$error("bvalid dropped before bready");
			failures++;
		end

endmodule

// control struct from cpuControl, write response from axiLiteSlave
bind cpuTop cpuTop_properties topProps (
	.Clock(Clock), .rstN(rstN), .busy(busy), .ctrl(ctrl), .bvalid(bvalid), .bready(bready)
);

//--- testbench/cpuTop_tb.sv
`timescale 1ns/1ps
module cpuTop_tb import busPkg::*; ();

	localparam int numTests = 11;
	localparam int numRegs = 16;
	localparam int waitLimit = 200;	// cycles per handshake, polls per busy wait

	typedef struct packed {
		logic [4:0] op;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic [31:0] valA;	// loaded into rb
		logic [31:0] valB;	// loaded into rc
	} stimEntry;

	logic Clock;
	logic rstN;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	stimEntry stimTable [numTests];
	string testName [numTests];
	logic [31:0] refRegs [numRegs];
	logic [31:0] refPc;
	int errorCount;
	int testCount;
	int failCount;
	int testStartErrors;

	cpuTop #(.numRegs(numRegs), .dataWidth(dataWidth)) cpuTop_inst (
		.Clock(Clock), .rstN(rstN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	always #5 Clock = ~Clock;

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error %s: expected %h, actual %h", name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic stopOnTimeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("SIMULATION FAILED");
		$finish;
	endtask

	task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data, output int waited);
		@(posedge Clock);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= 4'hF;
		wvalid <= 1'b1;
		waited = 0;
		do begin
			@(posedge Clock);
			waited++;
			if (waited > waitLimit) stopOnTimeout("write address and data to be accepted");
		end while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bready <= 1'b1;
		do begin
			@(posedge Clock);
			waited++;
			if (waited > 2 * waitLimit) stopOnTimeout("write response");
		end while (!bvalid);
		compareValue($sformatf("bresp at %h", addr), 32'd0, 32'(bresp));	// OKAY
		bready <= 1'b0;
	endtask

	task automatic axiRead(input logic [7:0] addr, output logic [31:0] data);
		int cycles;
		@(posedge Clock);
		araddr <= addr;
		arvalid <= 1'b1;
		cycles = 0;
		do begin
			@(posedge Clock);
			cycles++;
			if (cycles > waitLimit) stopOnTimeout("read address to be accepted");
		end while (!arready);
		arvalid <= 1'b0;
		rready <= 1'b1;
		do begin
			@(posedge Clock);
			cycles++;
			if (cycles > 2 * waitLimit) stopOnTimeout("read data");
		end while (!rvalid);
		data = rdata;	// rdata is registered, stable at the edge
		compareValue($sformatf("rresp at %h", addr), 32'd0, 32'(rresp));
		rready <= 1'b0;
	endtask

	task automatic waitIdle();
		logic [31:0] status;
		int polls;
		polls = 0;
		status = 32'd1;
		while (status[0]) begin
			axiRead(offStatus, status);
			polls++;
			if (polls > waitLimit) stopOnTimeout("the busy flag to fall");
		end
	endtask

	task automatic loadReg(input logic [3:0] idx, input logic [31:0] value);
		int waited;
		axiWrite(offMemData, value, waited);
		axiWrite(offLoad, {28'd0, idx}, waited);
		waitIdle();
		refRegs[idx] = value;
	endtask

	// independent model of the ALU, ror built from a doubled word
	function automatic logic [31:0] modelAlu(input logic [4:0] op, input logic [31:0] a,
		input logic [31:0] b);
		logic [63:0] doubled;
		logic [4:0] amount;
		amount = b[4:0];
		doubled = {a, a} >> amount;
		case (op)
			5'd3: return a + b;
			5'd4: return a - b;
			5'd5: return a & b;
			5'd6: return a | b;
			5'd8: return doubled[31:0];
			5'd9: return a >> amount;
			5'd11: return a << amount;
			default: return a;
		endcase
	endfunction

	function automatic bit opWrites(input logic [4:0] op);
		return op inside {5'd3, 5'd4, 5'd5, 5'd6, 5'd8, 5'd9, 5'd11};
	endfunction

	task automatic applyModel(input stimEntry entry);
		refPc = refPc + 1;	// every instruction advances the PC
		if (opWrites(entry.op)) begin
			refRegs[entry.ra] = modelAlu(entry.op, refRegs[entry.rb], refRegs[entry.rc]);
		end
	endtask

	task automatic checkState(input string name);
		logic [31:0] value;
		axiRead(offPc, value);
		compareValue({name, " PC"}, refPc, value);
		for (int i = 0; i < numRegs; i++) begin
			axiRead(offRegBase + 8'(4 * i), value);
			compareValue($sformatf("%s R%0d", name, i), refRegs[i], value);
		end
	endtask

	task automatic finishTest(input string name);
		testCount++;
		if (errorCount == testStartErrors) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: mismatch", name);
			failCount++;
		end
		testStartErrors = errorCount;
	endtask

	task automatic setEntry(input int idx, input string name, input logic [4:0] op,
		input logic [3:0] ra, input logic [3:0] rb, input logic [3:0] rc,
		input logic [31:0] valA, input logic [31:0] valB);
		stimTable[idx] = '{op: op, ra: ra, rb: rb, rc: rc, valA: valA, valB: valB};
		testName[idx] = name;
	endtask

	task automatic fillTable();
		setEntry(0, "shrRef", 5'd9, 4'd5, 4'd2, 4'd4, 32'd4, 32'd2);	// 32'h4A920000
		setEntry(1, "add", 5'd3, 4'd1, 4'd2, 4'd3, $urandom(), $urandom());
		setEntry(2, "sub", 5'd4, 4'd6, 4'd7, 4'd8, $urandom(), $urandom());
		setEntry(3, "and", 5'd5, 4'd9, 4'd10, 4'd11, $urandom(), $urandom());
		setEntry(4, "or", 5'd6, 4'd12, 4'd13, 4'd14, $urandom(), $urandom());
		setEntry(5, "shl", 5'd11, 4'd15, 4'd0, 4'd1, $urandom(), $urandom());
		setEntry(6, "shr", 5'd9, 4'd3, 4'd4, 4'd5, $urandom(), $urandom());
		setEntry(7, "ror", 5'd8, 4'd7, 4'd8, 4'd9, $urandom(), $urandom());
		setEntry(8, "addSelf", 5'd3, 4'd6, 4'd6, 4'd6, $urandom(), $urandom());
		setEntry(9, "noop0", 5'd0, 4'd1, 4'd2, 4'd3, $urandom(), $urandom());
		setEntry(10, "noop31", 5'd31, 4'd4, 4'd5, 4'd6, $urandom(), $urandom());
	endtask

	initial begin
		logic [31:0] value;
		logic [31:0] word;
		int firstWait;
		int secondWait;
		stimEntry entry;
		void'($urandom(32'h60b828cb));
		Clock = 1'b0;
		rstN <= 1'b0;
		awaddr <= '0;
		awvalid <= 1'b0;
		wdata <= '0;
		wstrb <= '0;
		wvalid <= 1'b0;
		bready <= 1'b0;
		araddr <= '0;
		arvalid <= 1'b0;
		rready <= 1'b0;
		errorCount = 0;
		testCount = 0;
		failCount = 0;
		testStartErrors = 0;
		refPc = '0;
		for (int i = 0; i < numRegs; i++) begin
			refRegs[i] = '0;
		end
		fillTable();
		repeat (4) @(posedge Clock);
		rstN <= 1'b1;

		axiRead(offStatus, value);
		compareValue("reset status", 32'd0, value);
		checkState("reset");
		finishTest("reset");

		for (int i = 0; i < numRegs; i++) begin
			loadReg(4'(i), $urandom());
			checkState($sformatf("load R%0d", i));	// other registers must not move
		end
		finishTest("loadAll");

		loadReg(4'd5, 32'h27);	// reference setup, R5 overwritten by shrRef
		for (int t = 0; t < numTests; t++) begin
			entry = stimTable[t];
			word = {entry.op, entry.ra, entry.rb, entry.rc, 15'd0};
			loadReg(entry.rb, entry.valA);
			loadReg(entry.rc, entry.valB);
			axiWrite(offMemData, word, firstWait);
			axiWrite(offExec, 32'd0, firstWait);
			waitIdle();
			applyModel(entry);
			checkState(testName[t]);
			finishTest(testName[t]);
		end

		// second exec write lands while the first instruction still runs
		entry = '{op: 5'd3, ra: 4'd6, rb: 4'd6, rc: 4'd7, valA: 32'd0, valB: 32'd0};
		loadReg(4'd6, $urandom());
		loadReg(4'd7, $urandom());
		axiWrite(offMemData, {entry.op, entry.ra, entry.rb, entry.rc, 15'd0}, firstWait);
		axiWrite(offExec, 32'd0, firstWait);
		axiWrite(offExec, 32'd0, secondWait);
		waitIdle();
		applyModel(entry);
		applyModel(entry);
		compareValue("execWhileBusy stall", 32'd1, {31'd0, secondWait >= 3});
		checkState("execWhileBusy");
		finishTest("execWhileBusy");

		value = 32'(cpuTop_inst.topProps.failures);
		if (value != 0) begin
			$display("%0d assertion failures during the run", value);
			errorCount += int'(value);
		end
		$display("tests %0d, failed %0d, mismatches %0d", testCount, failCount, errorCount);
		if (errorCount == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

//--- src.f
design/busPkg.sv
design/regFile.sv
design/busRegs.sv
design/aluUnit.sv
design/cpuControl.sv
design/axiLiteSlave.sv
design/cpuTop.sv
testbench/cpuTop_properties.sv
testbench/cpuTop_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= cpuTop_tb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
SIMARGS ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIMARGS))"; echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)
